// ==== rtx_pkg.sv ====
`default_nettype none

package rtx_pkg;

  // signed fixed point word
  localparam int FP_WIDTH = 16;
  // 4 fraction bits
  localparam int FP_FRAC_BITS = 4;

  typedef logic signed [FP_WIDTH-1:0] fp_t;

  // one whole unit
  localparam fp_t FP_ONE = fp_t'(1 << FP_FRAC_BITS);
  // 640 units for the default focal distance
  localparam fp_t FP_HALF_SCREEN_WIDTH = fp_t'(640 << FP_FRAC_BITS);

  // x in the top bits, z in the bottom
  localparam int VEC_WIDTH = 3 * FP_WIDTH;

  typedef struct packed {
    fp_t x;
    fp_t y;
    fp_t z;
  } vec3_t;

  // uart frame format
  localparam int MAX_UART_DATA_BYTES = 24;
  localparam int FLASH_DATA_WIDTH = MAX_UART_DATA_BYTES * 8;
  // holds a length of 0..24
  localparam int FLASH_LEN_WIDTH = $clog2(MAX_UART_DATA_BYTES + 1);
  localparam logic [7:0] FLASH_SYNC = 8'hA5;
  localparam int UART_CLKS_PER_BIT = 16;

  // scene storage sizes
  localparam int MAX_NUM_OBJS = 16;
  localparam int OBJ_IDX_WIDTH = $clog2(MAX_NUM_OBJS);
  localparam int COUNT_WIDTH = $clog2(MAX_NUM_OBJS + 1);
  localparam int NUM_MATS = 16;
  // core side material index is wider than the table
  localparam int MAT_IDX_WIDTH = 8;
  localparam int MAT_ADDR_WIDTH = $clog2(NUM_MATS);

  localparam int OBJ_WIDTH = VEC_WIDTH + FP_WIDTH + MAT_IDX_WIDTH;
  localparam int MAT_WIDTH = 32;

  // sphere as the core sees it
  typedef struct packed {
    vec3_t center;
    fp_t radius;
    logic [MAT_IDX_WIDTH-1:0] mat_idx;
  } object_t;

  // rgb565 color plus two 8 bit factors
  typedef struct packed {
    logic [15:0] color;
    logic [7:0] emission;
    logic [7:0] reflectivity;
  } material_t;

  localparam int DEFAULT_NUM_OBJS = 16;
  localparam int DEFAULT_MAX_BOUNCES = 3;

  // command byte of a flash frame
  typedef enum logic [7:0] {
    CMD_CAM_ORIGIN  = 8'h00,
    CMD_CAM_FORWARD = 8'h01,
    CMD_CAM_RIGHT   = 8'h02,
    CMD_CAM_UP      = 8'h03,
    CMD_OBJ_IDX     = 8'h04,
    CMD_OBJ_DATA    = 8'h05,
    CMD_NUM_OBJS    = 8'h06,
    CMD_MAX_BOUNCES = 8'h07,
    CMD_MAT_IDX     = 8'h08,
    CMD_MAT_DATA    = 8'h09
  } flash_cmd_e;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    WAIT_SYNC,
    GET_CMD,
    GET_LEN,
    GET_DATA
  } frame_state_e;

endpackage

`default_nettype wire

// ==== uart_receive.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_receive
  import rtx_pkg::*;
#(
  parameter int CLKS_PER_BIT = UART_CLKS_PER_BIT
) (
  input  wire        clk_rtx,
  input  wire        sys_rst,
  input  wire        rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  // two-flop synchronizer on the raw line
  logic rxd_meta;
  logic rxd_sync;

  rx_state_e state;
  logic [15:0] clk_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] shift_reg;
  logic half_done;
  logic bit_done;

  // middle of the start bit
  assign half_done = (clk_cnt == 16'(CLKS_PER_BIT / 2 - 1));
  // one full bit later is the middle of the next bit
  assign bit_done = (clk_cnt == 16'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      // line idles high
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state <= IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          // falling edge starts a frame
          if (!rxd_sync) begin
            state <= START;
          end
        end
        START: begin
          if (half_done) begin
            clk_cnt <= '0;
            // glitch shorter than half a bit goes back to idle
            state <= rxd_sync ? IDLE : DATA;
          end else begin
            clk_cnt <= clk_cnt + 16'd1;
          end
        end
        DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 16'd1;
          end
        end
        STOP: begin
          if (bit_done) begin
            clk_cnt <= '0;
            // framing error drops the byte
            rx_valid <= rxd_sync;
            state <= IDLE;
          end else begin
            clk_cnt <= clk_cnt + 16'd1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk_rtx) begin
    if (state == DATA && bit_done) begin
      shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
    if (state == STOP && bit_done && rxd_sync) begin
      rx_byte <= shift_reg;
    end
  end

  // a byte takes ten bit periods so strobes never touch
  assert property (@(posedge clk_rtx) disable iff (sys_rst) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== uart_memflash.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_memflash
  import rtx_pkg::*;
(
  input  wire                         clk_rtx,
  input  wire                         sys_rst,
  input  wire                         rx_valid,
  input  wire  [7:0]                  rx_byte,
  output logic                        flash_active,
  output logic                        flash_wen,
  output logic [7:0]                  flash_cmd,
  output logic [FLASH_DATA_WIDTH-1:0] flash_data
);

  frame_state_e state;
  // payload bytes still to come
  logic [FLASH_LEN_WIDTH-1:0] remaining;
  logic len_bad;
  logic sync_seen;

  // length outside 1..24 drops the frame
  assign len_bad = (rx_byte == 8'd0) || (rx_byte > 8'(MAX_UART_DATA_BYTES));
  assign sync_seen = rx_valid && (state == WAIT_SYNC) && (rx_byte == FLASH_SYNC);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state <= WAIT_SYNC;
      remaining <= '0;
      flash_active <= 1'b0;
      flash_wen <= 1'b0;
    end else begin
      flash_wen <= 1'b0;
      if (rx_valid) begin
        case (state)
          WAIT_SYNC: begin
            // anything but the sync byte is noise
            if (sync_seen) begin
              state <= GET_CMD;
              flash_active <= 1'b1;
            end
          end
          GET_CMD: begin
            state <= GET_LEN;
          end
          GET_LEN: begin
            if (len_bad) begin
              state <= WAIT_SYNC;
              flash_active <= 1'b0;
            end else begin
              remaining <= rx_byte[FLASH_LEN_WIDTH-1:0];
              state <= GET_DATA;
            end
          end
          GET_DATA: begin
            remaining <= remaining - 1'b1;
            // last payload byte fires the write
            if (remaining == FLASH_LEN_WIDTH'(1)) begin
              flash_wen <= 1'b1;
              flash_active <= 1'b0;
              state <= WAIT_SYNC;
            end
          end
          default: state <= WAIT_SYNC;
        endcase
      end
    end
  end

  // command and payload capture
  always_ff @(posedge clk_rtx) begin
    if (sync_seen) begin
      // short frames stay right aligned with zero upper bits
      flash_data <= '0;
    end else if (rx_valid && state == GET_DATA) begin
      // msb first so earlier bytes move up
      flash_data <= {flash_data[FLASH_DATA_WIDTH-9:0], rx_byte};
    end
    if (rx_valid && state == GET_CMD) begin
      flash_cmd <= rx_byte;
    end
  end

  // strobe only ever follows the payload phase
  assert property (@(posedge clk_rtx) disable iff (sys_rst)
    flash_wen |-> $past(state) == GET_DATA);

endmodule

`default_nettype wire

// ==== scene_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_config
  import rtx_pkg::*;
(
  input  wire                         clk_rtx,
  input  wire                         sys_rst,
  input  wire                         flash_wen,
  input  wire  [7:0]                  flash_cmd,
  input  wire  [FLASH_DATA_WIDTH-1:0] flash_data,
  output logic [VEC_WIDTH-1:0]        cam_origin,
  output logic [VEC_WIDTH-1:0]        cam_forward,
  output logic [VEC_WIDTH-1:0]        cam_right,
  output logic [VEC_WIDTH-1:0]        cam_up,
  output logic [7:0]                  max_bounces,
  output logic                        render_rst,
  output logic                        obj_wen,
  output logic [OBJ_IDX_WIDTH-1:0]    obj_widx,
  output logic [OBJ_WIDTH-1:0]        obj_wdata,
  output logic                        count_wen,
  output logic [7:0]                  count_wdata,
  output logic                        mat_wen,
  output logic [MAT_IDX_WIDTH-1:0]    mat_widx,
  output logic [MAT_WIDTH-1:0]        mat_wdata
);

  flash_cmd_e cmd;

  assign cmd = flash_cmd_e'(flash_cmd);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      // camera looks down +y from the origin
      cam_origin <= '0;
      cam_forward <= vec3_t'{x: '0, y: FP_HALF_SCREEN_WIDTH, z: '0};
      cam_right <= vec3_t'{x: FP_ONE, y: '0, z: '0};
      cam_up <= vec3_t'{x: '0, y: '0, z: FP_ONE};
      max_bounces <= 8'(DEFAULT_MAX_BOUNCES);
      obj_widx <= '0;
      mat_widx <= '0;
      obj_wen <= 1'b0;
      count_wen <= 1'b0;
      mat_wen <= 1'b0;
      // core stays in reset with the subsystem
      render_rst <= 1'b1;
    end else begin
      // any accepted frame restarts the render
      render_rst <= flash_wen;
      obj_wen <= flash_wen && (cmd == CMD_OBJ_DATA);
      count_wen <= flash_wen && (cmd == CMD_NUM_OBJS);
      mat_wen <= flash_wen && (cmd == CMD_MAT_DATA);
      if (flash_wen) begin
        case (cmd)
          CMD_CAM_ORIGIN:  cam_origin <= flash_data[VEC_WIDTH-1:0];
          CMD_CAM_FORWARD: cam_forward <= flash_data[VEC_WIDTH-1:0];
          CMD_CAM_RIGHT:   cam_right <= flash_data[VEC_WIDTH-1:0];
          CMD_CAM_UP:      cam_up <= flash_data[VEC_WIDTH-1:0];
          CMD_OBJ_IDX:     obj_widx <= flash_data[OBJ_IDX_WIDTH-1:0];
          CMD_MAX_BOUNCES: max_bounces <= flash_data[7:0];
          CMD_MAT_IDX:     mat_widx <= flash_data[MAT_IDX_WIDTH-1:0];
          // data and count commands only raise write strobes
          default: ;
        endcase
      end
    end
  end

  // write payloads follow the strobes
  always_ff @(posedge clk_rtx) begin
    if (flash_wen) begin
      obj_wdata <= flash_data[OBJ_WIDTH-1:0];
      count_wdata <= flash_data[7:0];
      mat_wdata <= flash_data[MAT_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== scene_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_buffer
  import rtx_pkg::*;
(
  input  wire                      clk_rtx,
  input  wire                      sys_rst,
  input  wire                      obj_wen,
  input  wire  [OBJ_IDX_WIDTH-1:0] obj_widx,
  input  wire  [OBJ_WIDTH-1:0]     obj_wdata,
  input  wire                      count_wen,
  input  wire  [7:0]               count_wdata,
  input  wire  [OBJ_IDX_WIDTH-1:0] obj_ridx,
  output logic [COUNT_WIDTH-1:0]   num_objs,
  output logic [OBJ_WIDTH-1:0]     obj,
  output logic                     obj_valid
);

  object_t mem [MAX_NUM_OBJS];

  // object ram
  // read before write on a shared entry
  always_ff @(posedge clk_rtx) begin
    if (obj_wen) begin
      mem[obj_widx] <= object_t'(obj_wdata);
    end
    obj <= mem[obj_ridx];
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      num_objs <= COUNT_WIDTH'(DEFAULT_NUM_OBJS);
      obj_valid <= 1'b0;
    end else begin
      if (count_wen) begin
        // saturate at capacity
        if (count_wdata > 8'(MAX_NUM_OBJS)) begin
          num_objs <= COUNT_WIDTH'(MAX_NUM_OBJS);
        end else begin
          num_objs <= count_wdata[COUNT_WIDTH-1:0];
        end
      end
      // qualify the slot being read
      obj_valid <= ({1'b0, obj_ridx} < num_objs);
    end
  end

  assert property (@(posedge clk_rtx) disable iff (sys_rst)
    num_objs <= COUNT_WIDTH'(MAX_NUM_OBJS));

endmodule

`default_nettype wire

// ==== material_dictionary.sv ====
`timescale 1ns/1ps
`default_nettype none

module material_dictionary
  import rtx_pkg::*;
(
  input  wire                      clk_rtx,
  input  wire                      sys_rst,
  input  wire                      mat_wen,
  input  wire  [MAT_IDX_WIDTH-1:0] mat_widx,
  input  wire  [MAT_WIDTH-1:0]     mat_wdata,
  input  wire  [MAT_IDX_WIDTH-1:0] mat_ridx,
  output logic [MAT_WIDTH-1:0]     mat
);

  material_t mem [NUM_MATS];
  // entries loaded since reset
  logic [NUM_MATS-1:0] written;
  logic wr_in_range;
  logic rd_in_range;

  assign wr_in_range = (mat_widx < MAT_IDX_WIDTH'(NUM_MATS));
  assign rd_in_range = (mat_ridx < MAT_IDX_WIDTH'(NUM_MATS));

  always_ff @(posedge clk_rtx) begin
    // writes past the table are lost
    if (mat_wen && wr_in_range) begin
      mem[mat_widx[MAT_ADDR_WIDTH-1:0]] <= material_t'(mat_wdata);
    end
    // all zero material flags an unknown index
    if (rd_in_range) begin
      mat <= mem[mat_ridx[MAT_ADDR_WIDTH-1:0]];
    end else begin
      mat <= '0;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      written <= '0;
    end else if (mat_wen && wr_in_range) begin
      written[mat_widx[MAT_ADDR_WIDTH-1:0]] <= 1'b1;
    end
  end

  // loaded entries read back clean
  assert property (@(posedge clk_rtx) disable iff (sys_rst)
    (rd_in_range && written[mat_ridx[MAT_ADDR_WIDTH-1:0]]) |=> !$isunknown(mat));

endmodule

`default_nettype wire

// ==== scene_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module scene_loader_top
  import rtx_pkg::*;
(
  input  wire                      clk_rtx,
  input  wire                      sys_rst,
  input  wire                      uart_rxd,
  input  wire  [OBJ_IDX_WIDTH-1:0] obj_ridx,
  input  wire  [MAT_IDX_WIDTH-1:0] mat_ridx,
  output logic                     flash_active,
  output logic                     render_rst,
  output logic [VEC_WIDTH-1:0]     cam_origin,
  output logic [VEC_WIDTH-1:0]     cam_forward,
  output logic [VEC_WIDTH-1:0]     cam_right,
  output logic [VEC_WIDTH-1:0]     cam_up,
  output logic [7:0]               max_bounces,
  output logic [COUNT_WIDTH-1:0]   num_objs,
  output logic [OBJ_WIDTH-1:0]     obj,
  output logic                     obj_valid,
  output logic [MAT_WIDTH-1:0]     mat
);

  // receiver to parser
  logic rx_valid;
  logic [7:0] rx_byte;

  // parser to decoder
  logic flash_wen;
  logic [7:0] flash_cmd;
  logic [FLASH_DATA_WIDTH-1:0] flash_data;

  // decoder to memories
  logic obj_wen;
  logic [OBJ_IDX_WIDTH-1:0] obj_widx;
  logic [OBJ_WIDTH-1:0] obj_wdata;
  logic count_wen;
  logic [7:0] count_wdata;
  logic mat_wen;
  logic [MAT_IDX_WIDTH-1:0] mat_widx;
  logic [MAT_WIDTH-1:0] mat_wdata;

  uart_receive #(
    .CLKS_PER_BIT(UART_CLKS_PER_BIT)
  ) u_uart_receive (
    .clk_rtx (clk_rtx),
    .sys_rst (sys_rst),
    .rxd     (uart_rxd),
    .rx_valid(rx_valid),
    .rx_byte (rx_byte)
  );

  uart_memflash u_uart_memflash (
    .clk_rtx     (clk_rtx),
    .sys_rst     (sys_rst),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .flash_active(flash_active),
    .flash_wen   (flash_wen),
    .flash_cmd   (flash_cmd),
    .flash_data  (flash_data)
  );

  scene_config u_scene_config (
    .clk_rtx    (clk_rtx),
    .sys_rst    (sys_rst),
    .flash_wen  (flash_wen),
    .flash_cmd  (flash_cmd),
    .flash_data (flash_data),
    .cam_origin (cam_origin),
    .cam_forward(cam_forward),
    .cam_right  (cam_right),
    .cam_up     (cam_up),
    .max_bounces(max_bounces),
    .render_rst (render_rst),
    .obj_wen    (obj_wen),
    .obj_widx   (obj_widx),
    .obj_wdata  (obj_wdata),
    .count_wen  (count_wen),
    .count_wdata(count_wdata),
    .mat_wen    (mat_wen),
    .mat_widx   (mat_widx),
    .mat_wdata  (mat_wdata)
  );

  scene_buffer u_scene_buffer (
    .clk_rtx    (clk_rtx),
    .sys_rst    (sys_rst),
    .obj_wen    (obj_wen),
    .obj_widx   (obj_widx),
    .obj_wdata  (obj_wdata),
    .count_wen  (count_wen),
    .count_wdata(count_wdata),
    .obj_ridx   (obj_ridx),
    .num_objs   (num_objs),
    .obj        (obj),
    .obj_valid  (obj_valid)
  );

  material_dictionary u_material_dictionary (
    .clk_rtx  (clk_rtx),
    .sys_rst  (sys_rst),
    .mat_wen  (mat_wen),
    .mat_widx (mat_widx),
    .mat_wdata(mat_wdata),
    .mat_ridx (mat_ridx),
    .mat      (mat)
  );

endmodule

`default_nettype wire

// ==== tb_scene_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_scene_loader
  import rtx_pkg::*;
();

  logic clk_rtx;
  logic sys_rst;
  logic uart_rxd;
  logic [OBJ_IDX_WIDTH-1:0] obj_ridx;
  logic [MAT_IDX_WIDTH-1:0] mat_ridx;
  logic flash_active;
  logic render_rst;
  logic [VEC_WIDTH-1:0] cam_origin;
  logic [VEC_WIDTH-1:0] cam_forward;
  logic [VEC_WIDTH-1:0] cam_right;
  logic [VEC_WIDTH-1:0] cam_up;
  logic [7:0] max_bounces;
  logic [COUNT_WIDTH-1:0] num_objs;
  logic [OBJ_WIDTH-1:0] obj;
  logic obj_valid;
  logic [MAT_WIDTH-1:0] mat;

  // reference model state
  logic [VEC_WIDTH-1:0] m_origin;
  logic [VEC_WIDTH-1:0] m_forward;
  logic [VEC_WIDTH-1:0] m_right;
  logic [VEC_WIDTH-1:0] m_up;
  logic [7:0] m_bounces;
  logic [COUNT_WIDTH-1:0] m_count;
  logic [OBJ_IDX_WIDTH-1:0] m_obj_widx;
  logic [MAT_IDX_WIDTH-1:0] m_mat_widx;
  logic [OBJ_WIDTH-1:0] m_obj [MAX_NUM_OBJS];
  logic m_obj_wr [MAX_NUM_OBJS];
  logic [MAT_WIDTH-1:0] m_mat [NUM_MATS];
  logic m_mat_wr [NUM_MATS];

  // next frame payload in send order
  logic [7:0] pay [MAX_UART_DATA_BYTES];

  // bus monitor state
  int rst_pulses;
  logic rst_prev;
  logic active_seen;
  logic mon_en;
  event compare_ev;

  int unsigned seed_val;
  int i;
  int k;
  int n;

  scene_loader_top u_scene_loader_top (
    .clk_rtx     (clk_rtx),
    .sys_rst     (sys_rst),
    .uart_rxd    (uart_rxd),
    .obj_ridx    (obj_ridx),
    .mat_ridx    (mat_ridx),
    .flash_active(flash_active),
    .render_rst  (render_rst),
    .cam_origin  (cam_origin),
    .cam_forward (cam_forward),
    .cam_right   (cam_right),
    .cam_up      (cam_up),
    .max_bounces (max_bounces),
    .num_objs    (num_objs),
    .obj         (obj),
    .obj_valid   (obj_valid),
    .mat         (mat)
  );

  initial begin
    clk_rtx = 1'b0;
    forever #4 clk_rtx = ~clk_rtx;
  end

  task automatic fail_text(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic fail_value(input string name, input logic [191:0] exp_v,
                            input logic [191:0] got_v);
    fail_text($sformatf("Error %s expected 0x%0h got 0x%0h", name, exp_v, got_v));
  endtask

  // msb first bytes right aligned
  function automatic logic [FLASH_DATA_WIDTH-1:0] right_align(input int len);
    logic [FLASH_DATA_WIDTH-1:0] acc;
    acc = '0;
    for (int j = 0; j < len; j++) begin
      acc = {acc[FLASH_DATA_WIDTH-9:0], pay[j]};
    end
    return acc;
  endfunction

  function automatic logic [COUNT_WIDTH-1:0] saturate_count(input logic [7:0] v);
    return (v > 8'(MAX_NUM_OBJS)) ? COUNT_WIDTH'(MAX_NUM_OBJS) : v[COUNT_WIDTH-1:0];
  endfunction

  function automatic logic [MAT_WIDTH-1:0] expected_mat(input logic [7:0] idx);
    return (idx < 8'(NUM_MATS)) ? m_mat[idx[3:0]] : '0;
  endfunction

  function automatic logic [7:0] pick_cam_cmd(input int sel);
    case (sel)
      0: return CMD_CAM_ORIGIN;
      1: return CMD_CAM_FORWARD;
      2: return CMD_CAM_RIGHT;
      3: return CMD_CAM_UP;
      default: return CMD_MAX_BOUNCES;
    endcase
  endfunction

  // decoder rules applied to the model
  task automatic model_apply(input logic [7:0] cmd, input logic [FLASH_DATA_WIDTH-1:0] data);
    case (cmd)
      CMD_CAM_ORIGIN: m_origin = data[VEC_WIDTH-1:0];
      CMD_CAM_FORWARD: m_forward = data[VEC_WIDTH-1:0];
      CMD_CAM_RIGHT: m_right = data[VEC_WIDTH-1:0];
      CMD_CAM_UP: m_up = data[VEC_WIDTH-1:0];
      CMD_OBJ_IDX: m_obj_widx = data[OBJ_IDX_WIDTH-1:0];
      CMD_OBJ_DATA: begin
        m_obj[m_obj_widx] = data[OBJ_WIDTH-1:0];
        m_obj_wr[m_obj_widx] = 1'b1;
      end
      CMD_NUM_OBJS: m_count = saturate_count(data[7:0]);
      CMD_MAX_BOUNCES: m_bounces = data[7:0];
      CMD_MAT_IDX: m_mat_widx = data[MAT_IDX_WIDTH-1:0];
      CMD_MAT_DATA: begin
        // out of range writes vanish
        if (m_mat_widx < 8'(NUM_MATS)) begin
          m_mat[m_mat_widx[3:0]] = data[MAT_WIDTH-1:0];
          m_mat_wr[m_mat_widx[3:0]] = 1'b1;
        end
      end
      default: ;
    endcase
  endtask

  task automatic fill_payload();
    for (int j = 0; j < MAX_UART_DATA_BYTES; j++) begin
      pay[j] = 8'($urandom);
    end
  endtask

  // 8N1 lsb first starting on a falling edge
  task automatic send_byte(input logic [7:0] val);
    uart_rxd = 1'b0;
    repeat (UART_CLKS_PER_BIT) @(negedge clk_rtx);
    for (int j = 0; j < 8; j++) begin
      uart_rxd = val[j];
      repeat (UART_CLKS_PER_BIT) @(negedge clk_rtx);
    end
    uart_rxd = 1'b1;
    repeat (UART_CLKS_PER_BIT) @(negedge clk_rtx);
  endtask

  task automatic send_frame(input logic [7:0] cmd, input logic [7:0] len_byte,
                            input int n_data, input int n_noise);
    logic [7:0] junk;
    active_seen = 1'b0;
    for (int j = 0; j < n_noise; j++) begin
      junk = 8'($urandom);
      if (junk == FLASH_SYNC) begin
        junk = 8'h5A;
      end
      send_byte(junk);
    end
    send_byte(FLASH_SYNC);
    send_byte(cmd);
    send_byte(len_byte);
    for (int j = 0; j < n_data; j++) begin
      send_byte(pay[j]);
    end
  endtask

  // count is bumped on negedges so sample it on posedges
  task automatic wait_restart(input int target);
    int cnt;
    cnt = 0;
    while (rst_pulses < target && cnt < UART_CLKS_PER_BIT * 40) begin
      @(posedge clk_rtx);
      cnt++;
    end
    assert (rst_pulses >= target) else fail_text("timeout waiting for render_rst pulse");
    @(negedge clk_rtx);
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (flash_active && cnt < UART_CLKS_PER_BIT * 40) begin
      @(negedge clk_rtx);
      cnt++;
    end
    assert (!flash_active) else fail_text("timeout waiting for flash_active to fall");
  endtask

  task automatic compare_now();
    -> compare_ev;
    @(negedge clk_rtx);
  endtask

  // good frame updates the model after its restart pulse
  task automatic load_frame(input logic [7:0] cmd, input int len, input int n_noise);
    int target;
    target = rst_pulses + 1;
    send_frame(cmd, 8'(len), len, n_noise);
    wait_restart(target);
    assert (active_seen) else fail_text("flash_active never went high during a frame");
    model_apply(cmd, right_align(len));
    compare_now();
  endtask

  // traffic that must leave every output alone
  task automatic reject_frame(input logic [7:0] len_byte, input logic has_sync);
    int target;
    logic [7:0] junk;
    target = rst_pulses;
    if (has_sync) begin
      send_frame(CMD_CAM_ORIGIN, len_byte, 0, 0);
    end else begin
      active_seen = 1'b0;
      for (int j = 0; j < 3; j++) begin
        junk = 8'($urandom);
        send_byte((junk == FLASH_SYNC) ? 8'h3C : junk);
      end
    end
    wait_idle();
    repeat (8) @(negedge clk_rtx);
    assert (rst_pulses == target) else fail_text("render_rst pulsed on a rejected frame");
    assert (active_seen == has_sync) else fail_text("flash_active did not match the traffic");
    compare_now();
  endtask

  task automatic check_obj(input logic [OBJ_IDX_WIDTH-1:0] idx);
    obj_ridx = idx;
    @(negedge clk_rtx);
    assert (obj_valid === ({1'b0, idx} < m_count))
      else fail_value("obj_valid", {1'b0, idx} < m_count, obj_valid);
    if (m_obj_wr[idx]) begin
      assert (obj === m_obj[idx]) else fail_value("obj", m_obj[idx], obj);
    end
  endtask

  task automatic check_mat(input logic [7:0] idx);
    mat_ridx = idx;
    @(negedge clk_rtx);
    if (idx >= 8'(NUM_MATS) || m_mat_wr[idx[3:0]]) begin
      assert (mat === expected_mat(idx)) else fail_value("mat", expected_mat(idx), mat);
    end
  endtask

  // render_rst pulse counter and width check
  always @(negedge clk_rtx) begin
    if (mon_en) begin
      if (render_rst) begin
        assert (!rst_prev) else fail_text("render_rst stayed high for more than one cycle");
        rst_pulses++;
      end
      rst_prev = render_rst;
      if (flash_active) begin
        active_seen = 1'b1;
      end
    end
  end

  // register outputs against the model
  always @(compare_ev) begin
    assert (cam_origin === m_origin) else fail_value("cam_origin", m_origin, cam_origin);
    assert (cam_forward === m_forward) else fail_value("cam_forward", m_forward, cam_forward);
    assert (cam_right === m_right) else fail_value("cam_right", m_right, cam_right);
    assert (cam_up === m_up) else fail_value("cam_up", m_up, cam_up);
    assert (max_bounces === m_bounces) else fail_value("max_bounces", m_bounces, max_bounces);
    assert (num_objs === m_count) else fail_value("num_objs", m_count, num_objs);
    assert (render_rst === 1'b0) else fail_value("render_rst", 0, render_rst);
  end

  initial begin
    seed_val = $urandom(32'h0c42_d3d5);
    sys_rst = 1'b1;
    uart_rxd = 1'b1;
    obj_ridx = '0;
    mat_ridx = '0;
    mon_en = 1'b0;
    rst_pulses = 0;
    rst_prev = 1'b0;
    active_seen = 1'b0;
    // reset defaults of the decoder
    m_origin = '0;
    m_forward = {16'h0000, FP_HALF_SCREEN_WIDTH, 16'h0000};
    m_right = {FP_ONE, 16'h0000, 16'h0000};
    m_up = {16'h0000, 16'h0000, FP_ONE};
    m_bounces = 8'd3;
    m_count = COUNT_WIDTH'(16);
    m_obj_widx = '0;
    m_mat_widx = '0;
    for (i = 0; i < MAX_NUM_OBJS; i++) begin
      m_obj_wr[i] = 1'b0;
    end
    for (i = 0; i < NUM_MATS; i++) begin
      m_mat_wr[i] = 1'b0;
    end
    repeat (3) @(negedge clk_rtx);
    sys_rst = 1'b0;

    // defaults right after reset
    assert (render_rst === 1'b1) else fail_value("render_rst", 1, render_rst);
    assert (obj_valid === 1'b0) else fail_value("obj_valid", 0, obj_valid);
    assert (flash_active === 1'b0) else fail_value("flash_active", 0, flash_active);
    @(negedge clk_rtx);
    assert (render_rst === 1'b0) else fail_value("render_rst", 0, render_rst);
    mon_en = 1'b1;
    compare_now();

    // camera vectors and bounce limit
    for (k = 0; k < 8; k++) begin
      fill_payload();
      load_frame(pick_cam_cmd($urandom % 5), 1 + ($urandom % MAX_UART_DATA_BYTES), 0);
    end

    // objects at random slots
    for (k = 0; k < 5; k++) begin
      fill_payload();
      load_frame(CMD_OBJ_IDX, 1, 0);
      fill_payload();
      load_frame(CMD_OBJ_DATA, 9 + ($urandom % 16), 0);
    end
    for (i = 0; i < MAX_NUM_OBJS; i++) begin
      check_obj(i[3:0]);
    end
    // object count saturates above 16
    for (k = 0; k < 4; k++) begin
      pay[0] = (k == 3) ? 8'd20 : 8'($urandom % 21);
      load_frame(CMD_NUM_OBJS, 1, 0);
      for (i = 0; i < MAX_NUM_OBJS; i++) begin
        check_obj(i[3:0]);
      end
    end

    // materials in range
    for (k = 0; k < 5; k++) begin
      pay[0] = 8'($urandom % NUM_MATS);
      load_frame(CMD_MAT_IDX, 1, 0);
      fill_payload();
      load_frame(CMD_MAT_DATA, 4 + ($urandom % 21), 0);
    end
    // out of range write whose low bits alias a loaded entry
    pay[0] = {4'(1 + ($urandom % 15)), m_mat_widx[3:0]};
    load_frame(CMD_MAT_IDX, 1, 0);
    fill_payload();
    load_frame(CMD_MAT_DATA, 4, 0);
    for (i = 0; i < NUM_MATS; i++) begin
      check_mat(i[7:0]);
    end
    check_mat(8'd16);
    check_mat(8'hFF);
    for (k = 0; k < 4; k++) begin
      check_mat(8'(NUM_MATS + ($urandom % 240)));
    end

    // malformed traffic
    reject_frame(8'd0, 1'b1);
    reject_frame(8'd25, 1'b1);
    reject_frame(8'd0, 1'b0);
    // stray bytes ahead of a good frame
    fill_payload();
    load_frame(CMD_CAM_UP, 6, 2);
    // unknown opcode only restarts the render
    for (k = 0; k < 2; k++) begin
      fill_payload();
      n = 10 + ($urandom % 246);
      load_frame(8'(n), 1 + ($urandom % MAX_UART_DATA_BYTES), 0);
    end
    for (i = 0; i < MAX_NUM_OBJS; i++) begin
      check_obj(i[3:0]);
    end
    for (i = 0; i < NUM_MATS; i++) begin
      check_mat(i[7:0]);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtx_pkg.sv
uart_receive.sv
uart_memflash.sv
scene_config.sv
scene_buffer.sv
material_dictionary.sv
scene_loader_top.sv
tb_scene_loader.sv

// ==== Bender.yml ====
package:
  name: scene_loader

sources:
  - files:
      - rtx_pkg.sv
      - uart_receive.sv
      - uart_memflash.sv
      - scene_config.sv
      - scene_buffer.sv
      - material_dictionary.sv
      - scene_loader_top.sv
  - target: test
    files:
      - tb_scene_loader.sv
